// File: include/keyer_consts.svh
`ifndef KEYER_CONSTS_SVH
`define KEYER_CONSTS_SVH

`define KEYER_ADDR_WIDTH 10
`define KEYER_SAMPLE_WIDTH 16

// Product is shifted right by this much, so 1 << shift is unity gain.
`define KEYER_GAIN_SHIFT 15

`define KEYER_WB_ADDR_WIDTH 13

// Byte offsets on the Wishbone bus.
`define KEYER_REG_LENGTH 13'h0000
`define KEYER_REG_GAIN 13'h0004
`define KEYER_TABLE_BASE 13'h1000

`endif

// File: rtl/keyer_pkg.sv
`include "keyer_consts.svh"

package keyer_pkg;

  typedef logic [`KEYER_ADDR_WIDTH-1:0] env_addr_t;
  typedef logic [`KEYER_SAMPLE_WIDTH-1:0] env_sample_t;
  typedef logic [`KEYER_SAMPLE_WIDTH-1:0] gain_t;

  typedef logic [`KEYER_WB_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  typedef enum logic [1:0]
  {
    RAMP_IDLE,
    RAMP_UP,
    RAMP_HOLD,
    RAMP_DOWN
  } ramp_state_t;

endpackage

// File: rtl/keyer_regs.sv
`timescale 1ns/1ps
`include "keyer_consts.svh"

module keyer_regs
(
  input  logic                   aclk,
  input  logic                   aresetn,

  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  keyer_pkg::wb_addr_t    wb_adr,
  input  keyer_pkg::wb_data_t    wb_dat_w,
  output keyer_pkg::wb_data_t    wb_dat_r,
  output logic                   wb_ack,

  output logic                   ram_en,
  output logic                   ram_we,
  output keyer_pkg::env_addr_t   ram_addr,
  output keyer_pkg::env_sample_t ram_wdata,
  input  keyer_pkg::env_sample_t ram_rdata,

  output keyer_pkg::env_addr_t   ramp_length,
  output keyer_pkg::gain_t       gain
);

  import keyer_pkg::*;

  logic req;
  logic sel_table, sel_length, sel_gain;
  logic rd_table, rd_length, rd_gain;

  assign req = wb_cyc && wb_stb && !wb_ack; // Ack cycle is not a new request.

  assign sel_table = |(wb_adr & `KEYER_TABLE_BASE);
  assign sel_length = !sel_table && (wb_adr == `KEYER_REG_LENGTH);
  assign sel_gain = !sel_table && (wb_adr == `KEYER_REG_GAIN);

  // Table entries are word addressed.
  assign ram_en = req && sel_table;
  assign ram_we = wb_we;
  assign ram_addr = wb_adr[`KEYER_ADDR_WIDTH+1:2];
  assign ram_wdata = wb_dat_w[`KEYER_SAMPLE_WIDTH-1:0];

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wb_ack <= 1'b0;
      rd_table <= 1'b0;
      rd_length <= 1'b0;
      rd_gain <= 1'b0;
      ramp_length <= '0;
      gain <= gain_t'(1 << `KEYER_GAIN_SHIFT);
    end
    else
    begin
      wb_ack <= req;
      if (req)
      begin
        rd_table <= sel_table;
        rd_length <= sel_length;
        rd_gain <= sel_gain;
        if (wb_we && sel_length)
        begin
          ramp_length <= wb_dat_w[`KEYER_ADDR_WIDTH-1:0];
        end
        if (wb_we && sel_gain)
        begin
          gain <= wb_dat_w[`KEYER_SAMPLE_WIDTH-1:0];
        end
      end
    end
  end

  // RAM data arrives in the ack cycle.
  always_comb
  begin
    wb_dat_r = '0;
    if (rd_table)
    begin
      wb_dat_r[`KEYER_SAMPLE_WIDTH-1:0] = ram_rdata;
    end
    else if (rd_gain)
    begin
      wb_dat_r[`KEYER_SAMPLE_WIDTH-1:0] = gain;
    end
    else if (rd_length)
    begin
      wb_dat_r[`KEYER_ADDR_WIDTH-1:0] = ramp_length;
    end
  end

  ack_single: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_ack |=> !wb_ack);

endmodule

// File: rtl/envelope_ram.sv
`timescale 1ns/1ps
`include "keyer_consts.svh"

module envelope_ram
(
  input  logic                   aclk,

  input  logic                   a_en,
  input  logic                   a_we,
  input  keyer_pkg::env_addr_t   a_addr,
  input  keyer_pkg::env_sample_t a_wdata,
  output keyer_pkg::env_sample_t a_rdata,

  input  logic                   b_en,
  input  keyer_pkg::env_addr_t   b_addr,
  output keyer_pkg::env_sample_t b_rdata
);

  import keyer_pkg::*;

  env_sample_t mem [0:(1 << `KEYER_ADDR_WIDTH)-1];

  // Host port, read-first.
  always_ff @(posedge aclk)
  begin
    if (a_en)
    begin
      if (a_we)
      begin
        mem[a_addr] <= a_wdata;
      end
      a_rdata <= mem[a_addr];
    end
  end

  // Ramp port is read only.
  always_ff @(posedge aclk)
  begin
    if (b_en)
    begin
      b_rdata <= mem[b_addr];
    end
  end

endmodule

// File: rtl/keyer_ramp.sv
`timescale 1ns/1ps

module keyer_ramp
(
  input  logic                 aclk,
  input  logic                 aresetn,

  input  logic                 key_flag,
  input  keyer_pkg::env_addr_t ramp_length,

  input  logic                 buf_room,
  output logic                 rd_en,
  output keyer_pkg::env_addr_t rd_addr
);

  import keyer_pkg::*;

  ramp_state_t state;
  env_addr_t addr;
  env_addr_t addr_inc;
  env_addr_t length_q;
  logic length_lowered;

  assign rd_en = buf_room; // Every cycle with room issues a read.
  assign rd_addr = addr;
  assign addr_inc = addr + 1'b1;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state <= RAMP_IDLE;
      addr <= '0;
    end
    else if (rd_en)
    begin
      case (state)
        RAMP_IDLE:
        begin
          if (key_flag && (ramp_length != '0))
          begin
            state <= RAMP_UP;
          end
        end
        RAMP_UP:
        begin
          if (addr >= ramp_length)
          begin
            state <= RAMP_HOLD; // Length was lowered under us.
          end
          else
          begin
            addr <= addr_inc;
            if (addr_inc == ramp_length)
            begin
              state <= RAMP_HOLD;
            end
          end
        end
        RAMP_HOLD:
        begin
          if (!key_flag)
          begin
            state <= RAMP_DOWN;
          end
        end
        RAMP_DOWN:
        begin
          if (addr <= env_addr_t'(1))
          begin
            addr <= '0;
            state <= RAMP_IDLE;
          end
          else
          begin
            addr <= addr - 1'b1;
          end
        end
        default:
        begin
          state <= RAMP_IDLE;
          addr <= '0;
        end
      endcase
    end
  end

  // Tracks a length drop until the ramp is back at idle.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      length_q <= '0;
      length_lowered <= 1'b0;
    end
    else
    begin
      length_q <= ramp_length;
      if (state == RAMP_IDLE)
      begin
        length_lowered <= 1'b0;
      end
      else if (ramp_length < length_q)
      begin
        length_lowered <= 1'b1;
      end
    end
  end

  addr_in_range: assert property (@(posedge aclk)
    disable iff (!aresetn || length_lowered || (ramp_length < length_q))
    addr <= ramp_length);

endmodule

// File: rtl/envelope_buffer.sv
`timescale 1ns/1ps

module envelope_buffer
(
  input  logic                   aclk,
  input  logic                   aresetn,

  input  logic                   rd_en,
  input  keyer_pkg::env_sample_t rd_data,
  output logic                   buf_room,

  output keyer_pkg::env_sample_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import keyer_pkg::*;

  logic wr;
  logic pop;
  logic [1:0] count;
  logic [1:0] holds;
  env_sample_t data0, data1;

  assign holds = count + {1'b0, wr}; // Stored plus the RAM word now on rd_data.

  // Empty buffer passes RAM data straight through.
  assign out_valid = (count != 2'd0) || wr;
  assign out_data = (count != 2'd0) ? data0 : rd_data;
  assign pop = out_valid && out_ready;

  // Leave space for the read that is still in flight.
  assign buf_room = (holds == 2'd0) || ((holds == 2'd1) && out_ready);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr <= 1'b0;
      count <= 2'd0;
    end
    else
    begin
      wr <= rd_en;
      count <= holds - {1'b0, pop};
    end
  end

  always_ff @(posedge aclk)
  begin
    case ({wr, pop})
      2'b10:
      begin
        if (count == 2'd0)
        begin
          data0 <= rd_data;
        end
        else
        begin
          data1 <= rd_data;
        end
      end
      2'b11:
      begin
        if (count == 2'd1)
        begin
          data0 <= rd_data;
        end
        else if (count == 2'd2)
        begin
          data0 <= data1;
          data1 <= rd_data;
        end
      end
      2'b01:
      begin
        data0 <= data1;
      end
      default:
      begin
      end
    endcase
  end

  no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    wr |-> (count < 2'd2));

endmodule

// File: rtl/envelope_gain.sv
`timescale 1ns/1ps
`include "keyer_consts.svh"

module envelope_gain
(
  input  logic                   aclk,
  input  logic                   aresetn,

  input  keyer_pkg::env_sample_t in_data,
  input  logic                   in_valid,
  output logic                   in_ready,

  input  keyer_pkg::gain_t       gain,

  output keyer_pkg::env_sample_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import keyer_pkg::*;

  localparam int PROD_WIDTH = 2 * `KEYER_SAMPLE_WIDTH;

  logic take;
  logic [PROD_WIDTH-1:0] product;
  logic [PROD_WIDTH-1:0] scaled;
  env_sample_t result;

  assign in_ready = !out_valid || out_ready;
  assign take = in_valid && in_ready;

  assign product = in_data * gain;
  assign scaled = product >> `KEYER_GAIN_SHIFT;
  assign result = (|scaled[PROD_WIDTH-1:`KEYER_SAMPLE_WIDTH]) ?
                  '1 : scaled[`KEYER_SAMPLE_WIDTH-1:0]; // Saturate.

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      out_valid <= 1'b0;
    end
    else if (take)
    begin
      out_valid <= 1'b1;
    end
    else if (out_ready)
    begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (take)
    begin
      out_data <= result;
    end
  end

  hold_on_stall: assert property (@(posedge aclk) disable iff (!aresetn)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

// File: rtl/keyer_top.sv
`timescale 1ns/1ps

module keyer_top
(
  input  logic                   aclk,
  input  logic                   aresetn,

  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  keyer_pkg::wb_addr_t    wb_adr,
  input  keyer_pkg::wb_data_t    wb_dat_w,
  output keyer_pkg::wb_data_t    wb_dat_r,
  output logic                   wb_ack,

  input  logic                   key_flag,

  output keyer_pkg::env_sample_t m_tdata,
  output logic                   m_tvalid,
  input  logic                   m_tready
);

  import keyer_pkg::*;

  logic ram_en, ram_we;
  env_addr_t ram_addr;
  env_sample_t ram_wdata, ram_rdata;
  env_addr_t ramp_length;
  gain_t gain;

  logic rd_en, buf_room;
  env_addr_t rd_addr;
  env_sample_t rd_data;

  env_sample_t buf_data;
  logic buf_valid, buf_ready;

  keyer_regs regs0 (
    .aclk(aclk), .aresetn(aresetn),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
    .ramp_length(ramp_length), .gain(gain)
  );

  envelope_ram ram0 (
    .aclk(aclk),
    .a_en(ram_en), .a_we(ram_we), .a_addr(ram_addr),
    .a_wdata(ram_wdata), .a_rdata(ram_rdata),
    .b_en(rd_en), .b_addr(rd_addr), .b_rdata(rd_data)
  );

  keyer_ramp ramp0 (
    .aclk(aclk), .aresetn(aresetn),
    .key_flag(key_flag), .ramp_length(ramp_length),
    .buf_room(buf_room), .rd_en(rd_en), .rd_addr(rd_addr)
  );

  envelope_buffer buf0 (
    .aclk(aclk), .aresetn(aresetn),
    .rd_en(rd_en), .rd_data(rd_data), .buf_room(buf_room),
    .out_data(buf_data), .out_valid(buf_valid), .out_ready(buf_ready)
  );

  envelope_gain gain0 (
    .aclk(aclk), .aresetn(aresetn),
    .in_data(buf_data), .in_valid(buf_valid), .in_ready(buf_ready),
    .gain(gain),
    .out_data(m_tdata), .out_valid(m_tvalid), .out_ready(m_tready)
  );

endmodule

// File: tb/tb_keyer.sv
`timescale 1ns/1ps
`include "keyer_consts.svh"

module tb_keyer;

  import keyer_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RAMP_LEN = 20;
  localparam int NUM_RANDOM = 8;
  localparam int ACK_LIMIT = 16;
  localparam int WAIT_LIMIT = 2000;
  localparam int HOLD_CYCLES = 60;
  localparam int NUM_WB = 12 + 2 * NUM_RANDOM + (RAMP_LEN + 1);
  localparam int NUM_WAITS = 12;
  localparam int RUN_CYCLES = RESET_CYCLES + NUM_WB * (ACK_LIMIT + 2)
                              + NUM_WAITS * WAIT_LIMIT + 4 * HOLD_CYCLES;
  localparam int MARGIN_CYCLES = 1000;

  logic aclk;
  logic aresetn;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic wb_ack;
  logic key_flag;
  env_sample_t m_tdata;
  logic m_tvalid;
  logic m_tready;

  logic ready_random;
  int accepted_count;
  gain_t gain_model;
  env_sample_t table_model [0:(1 << `KEYER_ADDR_WIDTH)-1];
  env_sample_t steps [$]; // Accepted samples with repeats collapsed.

  keyer_top dut0 (
    .aclk(aclk), .aresetn(aresetn),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .key_flag(key_flag),
    .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  always @(negedge aclk)
  begin
    m_tready <= ready_random ? 1'($urandom % 2) : 1'b1;
  end

  always @(posedge aclk)
  begin
    if (aresetn && m_tvalid && m_tready)
    begin
      accepted_count = accepted_count + 1;
      if ((steps.size() == 0) || (steps[$] !== m_tdata))
      begin
        steps.push_back(m_tdata);
      end
    end
  end

  function automatic env_sample_t scale_sample(env_sample_t sample, gain_t g);
    logic [31:0] product;
    product = (32'(sample) * 32'(g)) >> `KEYER_GAIN_SHIFT;
    return (product > 32'hFFFF) ? 16'hFFFF : product[15:0];
  endfunction

  function automatic wb_addr_t table_addr(int index);
    return `KEYER_TABLE_BASE | wb_addr_t'(index << 2);
  endfunction

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("** Error [%s] expected %0d, actual %0d", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic wb_access(logic we, wb_addr_t adr, wb_data_t wdata, output wb_data_t rdata);
    int waited;
    waited = 0;
    @(negedge aclk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    @(negedge aclk);
    while (!wb_ack)
    begin
      if (waited == ACK_LIMIT)
      begin
        stop_with_failure($sformatf("No Wishbone ack for address 0x%0h", adr));
      end
      waited++;
      @(negedge aclk);
    end
    rdata = wb_dat_r; // Valid in the ack cycle.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(wb_addr_t adr, wb_data_t data);
    wb_data_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(wb_addr_t adr, output wb_data_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic wait_accepted(int count);
    int target;
    int waited;
    target = accepted_count + count;
    waited = 0;
    while (accepted_count < target)
    begin
      if (waited == WAIT_LIMIT)
      begin
        stop_with_failure("Output stream stopped delivering samples");
      end
      waited++;
      @(negedge aclk);
    end
  endtask

  task automatic wait_steps(int count);
    int waited;
    waited = 0;
    while (steps.size() < count)
    begin
      if (waited == WAIT_LIMIT)
      begin
        stop_with_failure($sformatf("Output stream did not reach %0d steps", count));
      end
      waited++;
      @(negedge aclk);
    end
  endtask

  task automatic test_register_readback();
    wb_data_t data;
    int addr;
    int picked [$];
    wb_read(`KEYER_REG_LENGTH, data);
    check_equal("reset length", 0, data);
    wb_read(`KEYER_REG_GAIN, data);
    check_equal("reset gain", 32768, data);
    wb_write(`KEYER_REG_LENGTH, RAMP_LEN);
    wb_write(`KEYER_REG_GAIN, 32'h0000_4567);
    wb_read(`KEYER_REG_LENGTH, data);
    check_equal("length readback", RAMP_LEN, data);
    wb_read(`KEYER_REG_GAIN, data);
    check_equal("gain readback", 32'h4567, data);
    wb_write(`KEYER_REG_GAIN, 32768);
    gain_model = 16'd32768;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      addr = 64 + ($urandom % 960); // Clear of the ramp range.
      table_model[addr] = env_sample_t'($urandom);
      wb_write(table_addr(addr), {16'h0, table_model[addr]});
      picked.push_back(addr);
    end
    foreach (picked[i])
    begin
      wb_read(table_addr(picked[i]), data);
      check_equal($sformatf("table readback %0d", picked[i]), table_model[picked[i]], data);
    end
  endtask

  task automatic load_ramp_table();
    for (int i = 0; i <= RAMP_LEN; i++)
    begin
      table_model[i] = env_sample_t'(16'h0100 + 53 * i); // Strictly increasing.
      wb_write(table_addr(i), {16'h0, table_model[i]});
    end
  endtask

  task automatic test_idle_output(string name, env_sample_t expected);
    wait_accepted(8); // Flush samples made under the old settings.
    steps.delete();
    wait_accepted(32);
    check_equal({name, " step count"}, 1, steps.size());
    check_equal(name, expected, steps[0]);
  endtask

  task automatic test_ramp_up(string name);
    steps.delete();
    @(negedge aclk);
    key_flag = 1'b1;
    wait_steps(RAMP_LEN + 1);
    repeat (HOLD_CYCLES) @(negedge aclk);
    check_equal({name, " step count"}, RAMP_LEN + 1, steps.size());
    for (int i = 0; i <= RAMP_LEN; i++)
    begin
      check_equal($sformatf("%s step %0d", name, i),
                  scale_sample(table_model[i], gain_model), steps[i]);
    end
  endtask

  task automatic test_ramp_down(string name);
    int base;
    base = steps.size(); // List ends on the held top entry.
    @(negedge aclk);
    key_flag = 1'b0;
    wait_steps(base + RAMP_LEN);
    repeat (HOLD_CYCLES) @(negedge aclk);
    check_equal({name, " step count"}, base + RAMP_LEN, steps.size());
    for (int i = 0; i < RAMP_LEN; i++)
    begin
      check_equal($sformatf("%s step %0d", name, i),
                  scale_sample(table_model[RAMP_LEN - 1 - i], gain_model), steps[base + i]);
    end
  endtask

  task automatic test_back_pressure();
    ready_random = 1'b1;
    test_ramp_up("back-pressure ramp up");
    test_ramp_down("back-pressure ramp down");
    ready_random = 1'b0;
  endtask

  task automatic test_gain_saturation();
    wb_write(table_addr(0), 32'd1000);
    table_model[0] = 16'd1000;
    wb_write(`KEYER_REG_GAIN, 32'd40000);
    gain_model = 16'd40000;
    test_idle_output("gain above unity", scale_sample(table_model[0], gain_model));
    wb_write(table_addr(0), 32'h0000_F000);
    table_model[0] = 16'hF000;
    wb_write(`KEYER_REG_GAIN, 32'h0000_FFFF);
    gain_model = 16'hFFFF;
    test_idle_output("gain saturation", 16'hFFFF);
    wb_write(`KEYER_REG_GAIN, 32'd0);
    gain_model = 16'd0;
    test_idle_output("zero gain", 16'd0);
  endtask

  initial
  begin
    void'($urandom(14698));
    aresetn = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    key_flag = 1'b0;
    m_tready = 1'b0;
    ready_random = 1'b0;
    accepted_count = 0;
    gain_model = 16'd32768;
    repeat (RESET_CYCLES) @(negedge aclk);
    aresetn = 1'b1;
    test_register_readback();
    load_ramp_table();
    test_idle_output("idle output", scale_sample(table_model[0], gain_model));
    test_ramp_up("ramp up");
    test_ramp_down("ramp down");
    test_back_pressure();
    test_gain_saturation();
    $display("SIMULATION PASSED");
    $finish;
  end

  // Bound covers every test at its worst-case wait.
  initial
  begin
    #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish in %0d cycles",
             RUN_CYCLES + MARGIN_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: flist.f
+incdir+include
rtl/keyer_pkg.sv
rtl/keyer_regs.sv
rtl/envelope_ram.sv
rtl/keyer_ramp.sv
rtl/envelope_buffer.sv
rtl/envelope_gain.sv
rtl/keyer_top.sv
tb/tb_keyer.sv
